//--- source/bus_protocol_pkg.sv
// bus protocol widths, acknowledge codes, nop opcode and slave region constants
package bus_protocol_pkg;

   // address bus, bit 0 is the most significant bit
   localparam int addr_width = 30;

   // opcode and acknowledge field widths
   localparam int opc_width = 4;
   localparam int ack_width = 3;

   // address only cycle, no data phase follows
   localparam logic [opc_width-1:0] opc_nop = '0;

   // slave acknowledge codes
   localparam logic [ack_width-1:0] ack_rdy = 3'b001;   // phase done
   localparam logic [ack_width-1:0] ack_wat = 3'b010;   // stretch phase
   localparam logic [ack_width-1:0] ack_err = 3'b100;   // slave error
   // any other code means no slave answered

   // top two address bits that select slave 0
   localparam logic [1:0] sel_region = 2'b11;

endpackage

//--- source/bus_control_pkg.sv
// tenure state enumeration and data phase timeout limit of the bus controller
package bus_control_pkg;

   // tenure states of one bus master
   typedef enum logic [2:0]
   {
      st_idle,       // no master on the bus
      st_req,        // grant issued
      st_addr,       // address phase
      st_addrdata,   // locked address and data
      st_data        // data phase
   } tenure_state_t;

   // data phase stall counter
   localparam int timeout_width = 8;

   // cycles in a data phase before the tenure is aborted
   localparam logic [timeout_width-1:0] timeout_limit = 8'd255;

endpackage

//--- source/bus_cycle_if.sv
// decoded bus cycle interface with decode, fsm and result modports
`timescale 1ns/1ps

interface bus_cycle_if;

   logic is_nop;       // opcode carries no data
   logic lock;         // master keeps the bus
   logic ack_rdy;      // one-hot ack flags
   logic ack_wat;
   logic ack_err;
   logic region_hit;   // address in slave 0 region

   modport decode
   (
      output is_nop, lock, ack_rdy, ack_wat, ack_err, region_hit
   );

   modport fsm
   (
      input is_nop, lock, ack_rdy, ack_wat, ack_err
   );

   modport result
   (
      input region_hit
   );

endinterface

//--- source/bus_grant_if.sv
// grant, select and timeout decision interface with fsm and result modports
`timescale 1ns/1ps

interface bus_grant_if;

   logic grant_0;       // grant master 0 this cycle
   logic grant_1;       // grant master 1 this cycle
   logic sel_set;       // load select register
   logic sel_clear;     // drop select register
   logic timeout_hit;   // stall limit or error in data phase

   modport fsm
   (
      output grant_0, grant_1, sel_set, sel_clear, timeout_hit
   );

   modport result
   (
      input grant_0, grant_1, sel_set, sel_clear, timeout_hit
   );

endinterface

//--- source/bus_cycle_decode.sv
// bus_cycle_decode module classifying ack code, opcode, lock and address region
`timescale 1ns/1ps

module bus_cycle_decode
(
   input  logic [0:bus_protocol_pkg::addr_width-1] addr,
   input  logic [bus_protocol_pkg::opc_width-1:0]  opc,
   input  logic [bus_protocol_pkg::ack_width-1:0]  ack,
   input  logic                                    lock,
   bus_cycle_if.decode                             cyc
);

   import bus_protocol_pkg::*;

   always_comb
   begin
      // unknown codes leave all three flags low
      cyc.ack_rdy = (ack == ack_rdy);
      cyc.ack_wat = (ack == ack_wat);
      cyc.ack_err = (ack == ack_err);

      cyc.is_nop = (opc == opc_nop);   // address only tenure
      cyc.lock   = lock;

      // bit 0 is the msb, so the region sits in addr[0:1]
      cyc.region_hit = (addr[0:1] == sel_region);
   end

endmodule

//--- source/bus_tenure_fsm.sv
// bus_tenure_fsm module with arbitration, tenure state machine and timeout counter
`timescale 1ns/1ps

module bus_tenure_fsm
(
   input  logic     clk,
   input  logic     reset,
   input  logic     req_0,
   input  logic     req_1,
   bus_cycle_if.fsm cyc,
   bus_grant_if.fsm dec
);

   import bus_control_pkg::*;

   tenure_state_t            state;
   tenure_state_t            state_next;
   logic                     prio;        // 0 favors master 0
   logic                     prio_next;
   logic [timeout_width-1:0] count;       // data phase cycles
   logic [timeout_width-1:0] count_inc;
   logic                     counting;
   logic                     stall;       // end tenure with timeout

   // both requesting: pointer wins and flips; single request moves pointer away
   task automatic arbitrate
   (
      input  logic r0,
      input  logic r1,
      input  logic p,
      output logic g0,
      output logic g1,
      output logic p_next
   );
      g0     = 1'b0;
      g1     = 1'b0;
      p_next = p;
      if (r0 && r1)
      begin
         g0     = ~p;
         g1     = p;
         p_next = ~p;
      end
      else if (r0)
      begin
         g0     = 1'b1;
         p_next = 1'b1;
      end
      else if (r1)
      begin
         g1     = 1'b1;
         p_next = 1'b0;
      end
   endtask

   // hand the bus on if anyone waits, else park in idle
   task automatic release_bus
   (
      input  logic          r0,
      input  logic          r1,
      input  logic          p,
      output tenure_state_t nxt,
      output logic          g0,
      output logic          g1,
      output logic          p_next
   );
      arbitrate(r0, r1, p, g0, g1, p_next);
      nxt = (r0 || r1) ? st_req : st_idle;
   endtask

   assign counting  = (state == st_addrdata) || (state == st_data);
   assign count_inc = count + 1'b1;
   assign stall     = counting && ((count_inc == timeout_limit) || cyc.ack_err);

   always_comb
   begin
      state_next      = state;
      prio_next       = prio;
      dec.grant_0     = 1'b0;
      dec.grant_1     = 1'b0;
      dec.sel_set     = 1'b0;
      dec.sel_clear   = 1'b0;
      dec.timeout_hit = 1'b0;

      case (state)
         st_idle:
            if (req_0 || req_1)
            begin
               arbitrate(req_0, req_1, prio, dec.grant_0, dec.grant_1, prio_next);
               state_next = st_req;
            end
         st_req:
         begin
            dec.sel_set   = !cyc.is_nop;
            dec.sel_clear = cyc.is_nop;
            state_next    = st_addr;
         end
         st_addr:
            if (cyc.is_nop && cyc.lock)
               dec.sel_clear = 1'b1;   // locked nop holds the bus
            else if (cyc.is_nop)
            begin
               dec.sel_clear = 1'b1;
               release_bus(req_0, req_1, prio, state_next, dec.grant_0, dec.grant_1,
                           prio_next);
            end
            else if (!cyc.lock)
            begin
               dec.sel_clear = 1'b1;
               if (cyc.ack_rdy)
                  release_bus(req_0, req_1, prio, state_next, dec.grant_0, dec.grant_1,
                              prio_next);
               else if (cyc.ack_err)
                  state_next = st_idle;
               else
                  state_next = st_data;
            end
            else
            begin
               dec.sel_set   = cyc.ack_rdy;
               dec.sel_clear = !cyc.ack_rdy;
               state_next    = st_addrdata;
            end
         st_addrdata:
            if (stall)
            begin
               dec.timeout_hit = 1'b1;
               dec.sel_clear   = 1'b1;
               state_next      = st_idle;
            end
            else if (!cyc.lock && cyc.ack_rdy)
            begin
               dec.sel_clear = 1'b1;
               release_bus(req_0, req_1, prio, state_next, dec.grant_0, dec.grant_1,
                           prio_next);
            end
            else if (cyc.lock && cyc.ack_rdy && cyc.is_nop)
            begin
               dec.sel_clear = 1'b1;
               state_next    = st_addr;
            end
            else if (!(cyc.ack_rdy || cyc.ack_wat))
            begin
               dec.sel_clear = 1'b1;   // slave gone
               state_next    = st_idle;
            end
            else
            begin
               dec.sel_set   = cyc.ack_rdy && !cyc.is_nop;
               dec.sel_clear = !(cyc.ack_rdy && !cyc.is_nop);
            end
         st_data:
            if (stall)
            begin
               dec.timeout_hit = 1'b1;
               dec.sel_clear   = 1'b1;
               state_next      = st_idle;
            end
            else if (cyc.ack_rdy)
            begin
               dec.sel_clear = 1'b1;
               release_bus(req_0, req_1, prio, state_next, dec.grant_0, dec.grant_1,
                           prio_next);
            end
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         prio  <= 1'b0;
         count <= '0;
      end
      else
      begin
         state <= state_next;
         prio  <= prio_next;
         // restart on every state change
         count <= (counting && (state_next == state)) ? count_inc : '0;
      end
   end

   grant_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(dec.grant_0 && dec.grant_1));

   grant_needs_request: assert property (@(posedge clk) disable iff (reset)
      (dec.grant_0 |-> req_0) and (dec.grant_1 |-> req_1));

endmodule

//--- source/bus_output_stage.sv
// bus_output_stage module registering grant and timeout pulses and the slave select
`timescale 1ns/1ps

module bus_output_stage
(
   input  logic        clk,
   input  logic        reset,
   bus_cycle_if.result cyc,
   bus_grant_if.result dec,
   output logic        gnt_0,
   output logic        gnt_1,
   output logic        sel_0,
   output logic        tout
);

   logic sel_reg;   // slave 0 may be selected

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         gnt_0   <= 1'b0;
         gnt_1   <= 1'b0;
         tout    <= 1'b0;
         sel_reg <= 1'b0;
      end
      else
      begin
         gnt_0 <= dec.grant_0;       // one cycle after the decision
         gnt_1 <= dec.grant_1;
         tout  <= dec.timeout_hit;
         if (dec.sel_set)
            sel_reg <= 1'b1;
         else if (dec.sel_clear)
            sel_reg <= 1'b0;
      end
   end

   // region follows the live address
   assign sel_0 = sel_reg && cyc.region_hit;

   // fsm leaves the counting states on a timeout
   tout_single_pulse: assert property (@(posedge clk) disable iff (reset)
      tout |=> !tout);

   // a grant moves the fsm out of idle, so no back to back grants
   gnt_single_pulse: assert property (@(posedge clk) disable iff (reset)
      (gnt_0 || gnt_1) |=> !(gnt_0 || gnt_1));

endmodule

//--- source/bus_controller.sv
// bus_controller top level joining cycle decode, tenure fsm and output stage
`timescale 1ns/1ps

module bus_controller
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [0:bus_protocol_pkg::addr_width-1] addr,
   input  logic [bus_protocol_pkg::opc_width-1:0]  opc,
   input  logic [bus_protocol_pkg::ack_width-1:0]  ack,
   input  logic                                    lock,
   input  logic                                    req_0,
   input  logic                                    req_1,
   output logic                                    gnt_0,
   output logic                                    gnt_1,
   output logic                                    sel_0,
   output logic                                    tout
);

   bus_cycle_if cyc_if ();   // decoded cycle
   bus_grant_if dec_if ();   // fsm decisions

   bus_cycle_decode i_bus_cycle_decode
   (
      .addr (addr),
      .opc  (opc),
      .ack  (ack),
      .lock (lock),
      .cyc  (cyc_if.decode)
   );

   bus_tenure_fsm i_bus_tenure_fsm
   (
      .clk   (clk),
      .reset (reset),
      .req_0 (req_0),
      .req_1 (req_1),
      .cyc   (cyc_if.fsm),
      .dec   (dec_if.fsm)
   );

   bus_output_stage i_bus_output_stage
   (
      .clk   (clk),
      .reset (reset),
      .cyc   (cyc_if.result),
      .dec   (dec_if.result),
      .gnt_0 (gnt_0),
      .gnt_1 (gnt_1),
      .sel_0 (sel_0),
      .tout  (tout)
   );

endmodule

//--- testbench/bus_controller_tb.sv
// bus_controller_tb testbench with scenario table, arbitration model, checks and watchdog
`timescale 1ns/1ps

module bus_controller_tb;

   import bus_protocol_pkg::*;

   localparam int num_rows     = 12;
   localparam int reset_cycles = 16;
   localparam int tout_cycles  = 255;   // data phase cycles that end in a timeout
   localparam logic [ack_width-1:0] ack_none = 3'b000;   // no slave answer

   typedef struct packed
   {
      logic [1:0]           new_req;    // masters raising req on an idle bus
      logic [1:0]           late_req;   // masters raising req in the address phase
      logic [opc_width-1:0] opc;
      logic                 lock;
      logic [1:0]           region;     // top two address bits
      logic [8:0]           hold_len;   // wait or locked beats before the last ack
      logic [ack_width-1:0] end_ack;
      logic                 exp_win;
      logic                 exp_sel;
      logic                 exp_tout;
   } row_t;

   logic                   clk;
   logic                   reset;
   logic [0:addr_width-1]  addr;
   logic [opc_width-1:0]   opc;
   logic [ack_width-1:0]   ack;
   logic                   lock;
   logic                   req_0;
   logic                   req_1;
   logic                   gnt_0;
   logic                   gnt_1;
   logic                   sel_0;
   logic                   tout;

   row_t        rows [num_rows];
   logic [1:0]  levels;      // req lines as the masters hold them
   logic        ptr_model;   // predicted priority pointer
   logic        handoff;     // grant issued at the end of the last tenure
   logic [31:0] rand_state;

   bus_controller i_bus_controller
   (
      .clk   (clk),
      .reset (reset),
      .addr  (addr),
      .opc   (opc),
      .ack   (ack),
      .lock  (lock),
      .req_0 (req_0),
      .req_1 (req_1),
      .gnt_0 (gnt_0),
      .gnt_1 (gnt_1),
      .sel_0 (sel_0),
      .tout  (tout)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_output(input string name, input logic actual, input logic expected);
      assert (actual === expected)
      else abort_run($sformatf("** Error at %t: %s is %b, expected %b",
                               $time, name, actual, expected));
   endtask

   task automatic next_cycle;
      @(negedge clk);
   endtask

   task automatic drive_requests;
      req_0 = levels[0];
      req_1 = levels[1];
   endtask

   // both requesting: pointer wins and flips, a lone request points away from itself
   task automatic predict_winner(input logic [1:0] reqs, inout logic ptr, output logic win);
      if (reqs == 2'b11)
      begin
         win = ptr;
         ptr = ~ptr;
      end
      else
      begin
         win = !reqs[0];
         ptr = reqs[0];
      end
   endtask

   task automatic set_row
   (
      input int                   idx,
      input logic [1:0]           new_req,
      input logic [1:0]           late_req,
      input logic [opc_width-1:0] opc_v,
      input logic                 lock_v,
      input logic [1:0]           region_v,
      input int                   hold_v,
      input logic [ack_width-1:0] end_v,
      input logic                 win_v,
      input logic                 sel_v,
      input logic                 tout_v
   );
      rows[idx] = {new_req, late_req, opc_v, lock_v, region_v, 9'(hold_v), end_v,
                   win_v, sel_v, tout_v};
   endtask

   task automatic fill_table;
      // row  new    late   opc   lock  region hold end      win   sel   tout
      set_row(0,  2'b01, 2'b00, 4'd1, 1'b0, 2'b11,   2, ack_rdy, 1'b0, 1'b1, 1'b0);
      set_row(1,  2'b10, 2'b00, 4'd2, 1'b0, 2'b01,   1, ack_rdy, 1'b1, 1'b0, 1'b0);
      set_row(2,  2'b11, 2'b00, 4'd3, 1'b0, 2'b11,   0, ack_rdy, 1'b0, 1'b1, 1'b0);
      set_row(3,  2'b00, 2'b00, 4'd0, 1'b0, 2'b11,   0, ack_rdy, 1'b1, 1'b0, 1'b0);
      set_row(4,  2'b11, 2'b00, 4'd5, 1'b0, 2'b10,   3, ack_rdy, 1'b0, 1'b0, 1'b0);
      set_row(5,  2'b00, 2'b01, 4'd6, 1'b0, 2'b11,   1, ack_rdy, 1'b1, 1'b1, 1'b0);
      set_row(6,  2'b00, 2'b10, 4'd7, 1'b1, 2'b11,   3, ack_rdy, 1'b0, 1'b1, 1'b0);
      set_row(7,  2'b00, 2'b00, 4'd4, 1'b0, 2'b11,   2, ack_err, 1'b1, 1'b1, 1'b1);
      set_row(8,  2'b01, 2'b00, 4'd1, 1'b0, 2'b00, 255, ack_rdy, 1'b0, 1'b0, 1'b1);
      set_row(9,  2'b10, 2'b00, 4'd9, 1'b1, 2'b11,   2, ack_rdy, 1'b1, 1'b1, 1'b0);
      set_row(10, 2'b11, 2'b00, 4'd2, 1'b0, 2'b11,   0, ack_rdy, 1'b0, 1'b1, 1'b0);
      set_row(11, 2'b00, 2'b00, 4'd3, 1'b0, 2'b01,   1, ack_rdy, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic run_row(input int r);
      row_t        row;
      logic        win;
      logic        exp_sel;
      logic        exp_tout;
      logic        finished;
      int          n;
      logic [31:0] offset_word;
      row = rows[r];
      if (!handoff)
      begin
         if (levels == 2'b00)
            repeat ($urandom % 4) next_cycle();   // idle gap
         levels = levels | row.new_req;
         drive_requests();
         next_cycle();
      end
      assert (levels != 2'b00)
      else abort_run($sformatf("row %0d expects a grant but no master is requesting", r));
      predict_winner(levels, ptr_model, win);
      exp_sel = (row.opc != opc_nop) && (row.region == sel_region);
      assert ((win == row.exp_win) && (exp_sel == row.exp_sel))
      else abort_run($sformatf("row %0d of the scenario table disagrees with the model", r));
      check_output("gnt_0", gnt_0, !win);
      check_output("gnt_1", gnt_1, win);
      levels[win] = 1'b0;   // winner saw its grant
      drive_requests();
      offset_word = $urandom;
      opc  = row.opc;
      lock = row.lock;
      addr = {row.region, offset_word[addr_width-3:0]};
      ack  = ack_none;
      next_cycle();
      check_output("gnt_0", gnt_0, 1'b0);   // address phase
      check_output("gnt_1", gnt_1, 1'b0);
      check_output("sel_0", sel_0, exp_sel);
      levels = levels | row.late_req;
      drive_requests();
      exp_tout = 1'b0;
      if (row.opc == opc_nop)
         next_cycle();
      else
      begin
         ack = row.lock ? ack_rdy : ack_wat;
         next_cycle();
         n        = 0;
         finished = 1'b0;
         while (!finished)
         begin
            check_output("gnt_0", gnt_0, 1'b0);
            check_output("gnt_1", gnt_1, 1'b0);
            check_output("tout", tout, 1'b0);
            check_output("sel_0", sel_0, row.lock && exp_sel);   // locked beats keep select
            n++;
            if (n <= row.hold_len)
               ack = row.lock ? ack_rdy : ack_wat;
            else
            begin
               ack      = row.end_ack;
               lock     = 1'b0;
               finished = 1'b1;
            end
            if ((ack == ack_err) || (n == tout_cycles))
            begin
               exp_tout = 1'b1;
               finished = 1'b1;
            end
            next_cycle();
         end
      end
      assert (exp_tout == row.exp_tout)
      else abort_run($sformatf("row %0d timeout column disagrees with the model", r));
      check_output("tout", tout, exp_tout);
      check_output("sel_0", sel_0, 1'b0);
      ack     = ack_none;
      lock    = 1'b0;
      handoff = !exp_tout && (levels != 2'b00);
      if (!handoff)
      begin
         check_output("gnt_0", gnt_0, 1'b0);
         check_output("gnt_1", gnt_1, 1'b0);
      end
      if (exp_tout && (levels == 2'b00))
      begin
         next_cycle();
         check_output("tout", tout, 1'b0);   // single pulse
      end
   endtask

   initial
   begin
      $timeformat(-9, 0, " ns", 0);
      rand_state = 32'h4e6a_e980;
      void'($urandom(rand_state));
      clk       = 1'b0;
      reset     = 1'b1;
      addr      = '0;
      opc       = '0;
      ack       = ack_none;
      lock      = 1'b0;
      req_0     = 1'b0;
      req_1     = 1'b0;
      levels    = 2'b00;
      ptr_model = 1'b0;
      handoff   = 1'b0;
      fill_table();
      repeat (reset_cycles) next_cycle();
      reset = 1'b0;
      next_cycle();
      check_output("gnt_0", gnt_0, 1'b0);
      check_output("gnt_1", gnt_1, 1'b0);
      check_output("sel_0", sel_0, 1'b0);
      check_output("tout", tout, 1'b0);
      for (int r = 0; r < num_rows; r++)
         run_row(r);
      $display("test passed");
      $finish;
   end

   // every row finishes well inside one timeout plus margin
   initial
   begin
      repeat (num_rows * (tout_cycles + 20)) @(posedge clk);
      abort_run("watchdog expired because the run hung before all rows finished");
   end

endmodule

//--- bus_controller.f
source/bus_protocol_pkg.sv
source/bus_control_pkg.sv
source/bus_cycle_if.sv
source/bus_grant_if.sv
source/bus_cycle_decode.sv
source/bus_tenure_fsm.sv
source/bus_output_stage.sv
source/bus_controller.sv
testbench/bus_controller_tb.sv

//--- Bender.yml
package:
  name: bus_controller

sources:
  # packages first, then interfaces, then the RTL blocks and the top level
  - files:
      - source/bus_protocol_pkg.sv
      - source/bus_control_pkg.sv
      - source/bus_cycle_if.sv
      - source/bus_grant_if.sv
      - source/bus_cycle_decode.sv
      - source/bus_tenure_fsm.sv
      - source/bus_output_stage.sv
      - source/bus_controller.sv

  - target: simulation
    files:
      - testbench/bus_controller_tb.sv
